/* design/cpuPkg.sv */
package cpuPkg;

	// Machine word width
	parameter int xlen = 32;

	////////////////////////////////////////////////////////////
	// RV32I major opcodes, the kept subset only
	////////////////////////////////////////////////////////////
	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opImm    = 7'b0010011,
		opReg    = 7'b0110011
	} opcodeT;

	// Immediate layouts
	typedef enum logic [2:0] {
		immI,
		immS,
		immB,
		immU,
		immJ
	} immTypeT;

	// ALU functions, passB serves lui
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB
	} aluOpT;

	// Same encoding as load/store funct3
	typedef enum logic [2:0] {
		memByte  = 3'b000,
		memHalf  = 3'b001,
		memWord  = 3'b010,
		memByteU = 3'b100,
		memHalfU = 3'b101
	} memTypeT;

endpackage

/* design/decodeIf.sv */
`timescale 1ns/1ps

interface decodeIf import cpuPkg::*; ();

	// Execute controls
	aluOpT            aluOp;
	memTypeT          memType;
	// Register operands and immediate
	logic [xlen-1:0]  srcA;
	logic [xlen-1:0]  srcB;
	logic [xlen-1:0]  immValue;
	// Operand muxing
	logic             immSel;
	logic             pcOperand;
	// Data bus strobes
	logic             memRead;
	logic             memWrite;
	// Load extension and link select
	logic             setDataZero;
	logic             addConstant4;
	logic [xlen-1:0]  currPc;

	modport decoder (
		output aluOp, memType, srcA, srcB, immValue, immSel, pcOperand,
		output memRead, memWrite, setDataZero, addConstant4, currPc
	);

	modport executer (
		input aluOp, memType, srcA, srcB, immValue, immSel, pcOperand,
		input memRead, memWrite, setDataZero, addConstant4, currPc
	);

endinterface

/* design/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
	input  logic [xlen-1:0] instr,
	input  logic            reset,
	output aluOpT           aluOp,
	output immTypeT         immType,
	output logic            immSel,
	output logic            pcOperand,
	output logic            setDataZero,
	output logic            regWrite,
	output logic            memRead,
	output logic            memWrite,
	output logic            branch,
	output logic            jump,
	output logic            addConstant4,
	output memTypeT         memType
);

	opcodeT     opcode;
	logic [2:0] funct3;
	logic       funct7Bit;
	// Strobes before reset gating
	logic       regWriteRaw;
	logic       memReadRaw;
	logic       memWriteRaw;

	assign opcode    = opcodeT'(instr[6:0]);
	assign funct3    = instr[14:12];
	// Only bit 30 of funct7 matters in RV32I
	assign funct7Bit = instr[30];

	////////////////////////////////////////////////////////////
	// Opcode decode
	////////////////////////////////////////////////////////////
	always_comb begin
		// Defaults, everything idle
		aluOp        = aluAdd;
		immType      = immI;
		immSel       = 1'b0;
		pcOperand    = 1'b0;
		setDataZero  = 1'b0;
		regWriteRaw  = 1'b0;
		memReadRaw   = 1'b0;
		memWriteRaw  = 1'b0;
		branch       = 1'b0;
		jump         = 1'b0;
		addConstant4 = 1'b0;
		memType      = memWord;
		case (opcode)
			opLui: begin
				aluOp       = aluPassB;
				immType     = immU;
				immSel      = 1'b1;
				regWriteRaw = 1'b1;
			end
			opAuipc: begin
				immType     = immU;
				immSel      = 1'b1;
				pcOperand   = 1'b1;
				regWriteRaw = 1'b1;
			end
			// Both jumps link PC+4
			opJal, opJalr: begin
				immType      = (opcode == opJal) ? immJ : immI;
				immSel       = 1'b1;
				jump         = 1'b1;
				addConstant4 = 1'b1;
				regWriteRaw  = 1'b1;
			end
			opBranch: begin
				immType = immB;
				branch  = 1'b1;
			end
			opLoad: begin
				immSel      = 1'b1;
				memReadRaw  = 1'b1;
				regWriteRaw = 1'b1;
				memType     = memTypeT'(funct3);
				// lbu and lhu have funct3 bit 2 set
				setDataZero = funct3[2];
			end
			opStore: begin
				immType     = immS;
				immSel      = 1'b1;
				memWriteRaw = 1'b1;
				memType     = memTypeT'(funct3);
			end
			opImm, opReg: begin
				immSel      = (opcode == opImm);
				regWriteRaw = 1'b1;
				case (funct3)
					// No subi, so sub only for register form
					3'b000: aluOp = (opcode == opReg && funct7Bit) ? aluSub : aluAdd;
					3'b001: aluOp = aluSll;
					3'b010: aluOp = aluSlt;
					3'b011: aluOp = aluSltu;
					3'b100: aluOp = aluXor;
					3'b101: aluOp = funct7Bit ? aluSra : aluSrl;
					3'b110: aluOp = aluOr;
					default: aluOp = aluAnd;
				endcase
			end
			default: begin
				// Unknown opcode, all strobes stay low
				aluOp = aluAdd;
			end
		endcase
	end

	// No state change while reset is high
	assign regWrite = regWriteRaw & ~reset;
	assign memRead  = memReadRaw & ~reset;
	assign memWrite = memWriteRaw & ~reset;

endmodule

/* design/immExtend.sv */
`timescale 1ns/1ps

module immExtend import cpuPkg::*; (
	input  immTypeT         immType,
	input  logic [xlen-1:0] instr,
	output logic [xlen-1:0] immediate
);

	// Bit 31 is the sign in every layout
	logic signBit;

	assign signBit = instr[31];

	always_comb begin
		case (immType)
			immS:
				immediate = {{(xlen-12){signBit}}, instr[31:25], instr[11:7]};
			// Branch offset, bit 0 implied zero
			immB:
				immediate = {{(xlen-13){signBit}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			// Upper 20 bits, low 12 cleared
			immU:
				immediate = {instr[31:12], 12'b0};
			// Jump offset, bit 0 implied zero
			immJ:
				immediate = {{(xlen-21){signBit}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			default:
				immediate = {{(xlen-12){signBit}}, instr[31:20]};
		endcase
	end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps

module regFile import cpuPkg::*; #(
	parameter int regAddrWidth = 5
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [regAddrWidth-1:0] rdAddrA,
	input  logic [regAddrWidth-1:0] rdAddrB,
	input  logic [regAddrWidth-1:0] wrAddr,
	input  logic [xlen-1:0]         wrData,
	input  logic                    wrEnable,
	output logic [xlen-1:0]         rdDataA,
	output logic [xlen-1:0]         rdDataB
);

	logic [xlen-1:0] regs [2**regAddrWidth];

	// Single write port, x0 never stored
	always_ff @(posedge clk) begin
		if (wrEnable && !reset && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Asynchronous reads, x0 forced to zero
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

/* design/branchUnit.sv */
`timescale 1ns/1ps

module branchUnit import cpuPkg::*; (
	input  logic            branch,
	input  logic            jump,
	input  logic [xlen-1:0] currPc,
	input  logic [xlen-1:0] pcPlus4,
	input  logic [xlen-1:0] immediate,
	input  logic [xlen-1:0] srcA,
	input  logic [xlen-1:0] srcB,
	input  logic [2:0]      funct3,
	input  opcodeT          opcode,
	output logic [xlen-1:0] newPc
);

	logic            taken;
	logic [xlen-1:0] jalrTarget;

	// Branch condition from funct3
	always_comb begin
		case (funct3)
			3'b000: taken = (srcA == srcB);
			3'b001: taken = (srcA != srcB);
			3'b100: taken = ($signed(srcA) < $signed(srcB));
			3'b101: taken = ($signed(srcA) >= $signed(srcB));
			3'b110: taken = (srcA < srcB);
			3'b111: taken = (srcA >= srcB);
			default: taken = 1'b0;
		endcase
	end

	// Register-relative target, bit 0 dropped
	assign jalrTarget = (srcA + immediate) & ~{{(xlen-1){1'b0}}, 1'b1};

	always_comb begin
		if (jump && opcode == opJalr) begin
			newPc = jalrTarget;
		end else if (jump || (branch && taken)) begin
			newPc = currPc + immediate;
		end else begin
			newPc = pcPlus4;
		end
	end

endmodule

/* design/decode.sv */
`timescale 1ns/1ps

module decode import cpuPkg::*; #(
	parameter int regAddrWidth = 5
) (
	input  logic            clk,
	input  logic            reset,
	input  logic [xlen-1:0] instruction,
	input  logic [xlen-1:0] currPc,
	input  logic [xlen-1:0] pcPlus4,
	input  logic [xlen-1:0] writeData,
	output logic [xlen-1:0] updatePc,
	decodeIf.decoder        dec
);

	immTypeT         immType;
	logic            regWrite;
	logic            branch;
	logic            jump;
	// Operands shared by the interface and the branch unit
	logic [xlen-1:0] srcA;
	logic [xlen-1:0] srcB;
	logic [xlen-1:0] immValue;

	////////////////////////////////////////////////////////////
	// Control and immediate
	////////////////////////////////////////////////////////////
	controlUnit controlInst (
		.instr(instruction), .reset(reset),
		.aluOp(dec.aluOp), .immType(immType), .immSel(dec.immSel),
		.pcOperand(dec.pcOperand), .setDataZero(dec.setDataZero), .regWrite(regWrite),
		.memRead(dec.memRead), .memWrite(dec.memWrite), .branch(branch), .jump(jump),
		.addConstant4(dec.addConstant4), .memType(dec.memType)
	);

	immExtend immInst (.immType(immType), .instr(instruction), .immediate(immValue));

	////////////////////////////////////////////////////////////
	// Register file, rs1 rs2 rd taken from fixed fields
	////////////////////////////////////////////////////////////
	regFile #(.regAddrWidth(regAddrWidth)) regInst (
		.clk(clk), .reset(reset),
		.rdAddrA(instruction[15 +: regAddrWidth]), .rdAddrB(instruction[20 +: regAddrWidth]),
		.wrAddr(instruction[7 +: regAddrWidth]), .wrData(writeData), .wrEnable(regWrite),
		.rdDataA(srcA), .rdDataB(srcB)
	);

	// Next PC
	branchUnit branchInst (
		.branch(branch), .jump(jump), .currPc(currPc), .pcPlus4(pcPlus4),
		.immediate(immValue), .srcA(srcA), .srcB(srcB), .funct3(instruction[14:12]),
		.opcode(opcodeT'(instruction[6:0])), .newPc(updatePc)
	);

	assign dec.srcA     = srcA;
	assign dec.srcB     = srcB;
	assign dec.immValue = immValue;
	assign dec.currPc   = currPc;

endmodule

/* design/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit import cpuPkg::*; (
	decodeIf.executer       dec,
	input  logic [xlen-1:0] pcPlus4,
	input  logic [xlen-1:0] dataRdData,
	output logic [xlen-1:0] writeData,
	output logic [xlen-1:0] dataAddr,
	output logic [xlen-1:0] dataWrData,
	output logic [3:0]      dataByteEn,
	output logic            dataRead,
	output logic            dataWrite
);

	logic [xlen-1:0] aluA;
	logic [xlen-1:0] aluB;
	logic [4:0]      shamt;
	logic [xlen-1:0] aluResult;
	logic [1:0]      byteOffset;
	logic [3:0]      laneMask;
	// Read word shifted so the addressed lane sits at bit 0
	logic [xlen-1:0] loadShift;
	logic [xlen-1:0] loadValue;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////
	assign aluA  = dec.pcOperand ? dec.currPc : dec.srcA;
	assign aluB  = dec.immSel ? dec.immValue : dec.srcB;
	assign shamt = aluB[4:0];

	always_comb begin
		case (dec.aluOp)
			aluSub:   aluResult = aluA - aluB;
			aluSll:   aluResult = aluA << shamt;
			aluSlt:   aluResult = {{(xlen-1){1'b0}}, $signed(aluA) < $signed(aluB)};
			aluSltu:  aluResult = {{(xlen-1){1'b0}}, aluA < aluB};
			aluXor:   aluResult = aluA ^ aluB;
			aluSrl:   aluResult = aluA >> shamt;
			aluSra:   aluResult = $unsigned($signed(aluA) >>> shamt);
			aluOr:    aluResult = aluA | aluB;
			aluAnd:   aluResult = aluA & aluB;
			aluPassB: aluResult = aluB;
			default:  aluResult = aluA + aluB;
		endcase
	end

	// Word-aligned bus address, low bits pick the lane
	assign dataAddr   = {aluResult[xlen-1:2], 2'b00};
	assign byteOffset = aluResult[1:0];

	////////////////////////////////////////////////////////////
	// Store lanes
	////////////////////////////////////////////////////////////
	always_comb begin
		case (dec.memType)
			memByte, memByteU: begin
				dataWrData = {4{dec.srcB[7:0]}};
				laneMask   = 4'b0001 << byteOffset;
			end
			memHalf, memHalfU: begin
				dataWrData = {2{dec.srcB[15:0]}};
				laneMask   = byteOffset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				dataWrData = dec.srcB;
				laneMask   = 4'b1111;
			end
		endcase
	end

	// Lanes only asserted for a store
	assign dataByteEn = dec.memWrite ? laneMask : 4'b0000;
	assign dataRead   = dec.memRead;
	assign dataWrite  = dec.memWrite;

	// Load extraction and extension
	assign loadShift = dataRdData >> {byteOffset, 3'b000};

	always_comb begin
		case (dec.memType)
			memByte, memByteU:
				loadValue = {{(xlen-8){~dec.setDataZero & loadShift[7]}}, loadShift[7:0]};
			memHalf, memHalfU:
				loadValue = {{(xlen-16){~dec.setDataZero & loadShift[15]}}, loadShift[15:0]};
			default:
				loadValue = dataRdData;
		endcase
	end

	// Writeback source
	assign writeData = dec.memRead ? loadValue : (dec.addConstant4 ? pcPlus4 : aluResult);

endmodule

/* design/riscvCore.sv */
`timescale 1ns/1ps

module riscvCore import cpuPkg::*; #(
	parameter int regAddrWidth = 5
) (
	input  logic            clk,
	input  logic            reset,
	input  logic [xlen-1:0] instruction,
	input  logic [xlen-1:0] dataRdData,
	output logic [xlen-1:0] instrAddr,
	output logic [xlen-1:0] dataAddr,
	output logic [xlen-1:0] dataWrData,
	output logic [3:0]      dataByteEn,
	output logic            dataRead,
	output logic            dataWrite
);

	logic [xlen-1:0] pc;
	logic [xlen-1:0] pcPlus4;
	logic [xlen-1:0] updatePc;
	logic [xlen-1:0] writeData;

	decodeIf decBus ();

	////////////////////////////////////////////////////////////
	// Program counter, one instruction per cycle
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= updatePc;
		end
	end

	assign pcPlus4   = pc + 4;
	assign instrAddr = pc;

	decode #(.regAddrWidth(regAddrWidth)) decodeInst (
		.clk(clk), .reset(reset), .instruction(instruction), .currPc(pc),
		.pcPlus4(pcPlus4), .writeData(writeData), .updatePc(updatePc), .dec(decBus.decoder)
	);

	// ALU, data bus and writeback
	executeUnit executeInst (
		.dec(decBus.executer), .pcPlus4(pcPlus4), .dataRdData(dataRdData),
		.writeData(writeData), .dataAddr(dataAddr), .dataWrData(dataWrData),
		.dataByteEn(dataByteEn), .dataRead(dataRead), .dataWrite(dataWrite)
	);

endmodule

/* dv/riscvCore_assertions.sv */
`timescale 1ns/1ps

module riscvCore_assertions (
	input logic        clk,
	input logic        reset,
	input logic [31:0] instruction,
	input logic [31:0] instrAddr,
	input logic [3:0]  dataByteEn,
	input logic        dataRead,
	input logic        dataWrite
);

	// Failure count, watched by the testbench
	int          errorCount = 0;
	logic [31:0] lastAddr;
	logic        isControl;
	logic        isLoad;

	// Branch, jal and jalr may redirect the fetch
	assign isControl = instruction[6:0] inside {7'b1100011, 7'b1101111, 7'b1100111};
	// Load opcode, the only one that reads the data bus
	assign isLoad    = instruction[6:0] == 7'b0000011;

	// Fetch address of the previous cycle
	always_ff @(posedge clk) begin
		lastAddr <= instrAddr;
	end

	////////////////////////////////////////////////////////////
	// Reset behavior
	////////////////////////////////////////////////////////////
	resetPc: assert property (@(posedge clk) $past(reset) |-> instrAddr == 32'h0)
		else begin
			$error("FAIL %0t instrAddr got %h expected 00000000", $time, $sampled(instrAddr));
			errorCount++;
		end

	// No store while reset or just after it
	resetStore: assert property (@(posedge clk) (reset || $past(reset)) |-> !dataWrite)
		else begin
			$error("FAIL %0t dataWrite got %b expected 0", $time, $sampled(dataWrite));
			errorCount++;
		end

	////////////////////////////////////////////////////////////
	// Sequential fetch
	////////////////////////////////////////////////////////////
	pcStep: assert property (@(posedge clk) (!reset && !isControl) |=>
		instrAddr == lastAddr + 32'd4)
		else begin
			$error("FAIL %0t instrAddr got %h expected %h", $time, $sampled(instrAddr),
				$sampled(lastAddr) + 32'd4);
			errorCount++;
		end

	// Data bus
	laneIdle: assert property (@(posedge clk) !dataWrite |-> dataByteEn == 4'b0000)
		else begin
			$error("FAIL %0t dataByteEn got %b expected 0000", $time, $sampled(dataByteEn));
			errorCount++;
		end

	// Read strobe on loads only, held low in reset
	readOnLoad: assert property (@(posedge clk) dataRead == (!reset && isLoad))
		else begin
			$error("FAIL %0t dataRead got %b expected %b", $time, $sampled(dataRead),
				!$sampled(reset) && $sampled(isLoad));
			errorCount++;
		end

endmodule

/* dv/riscvCoreTb.sv */
`timescale 1ns/1ps

module riscvCoreTb;

	localparam int          progWords = 74;
	// Last word holds the jal to itself
	localparam logic [31:0] endAddr   = (progWords - 1) * 4;
	localparam logic [31:0] nopWord   = 32'h0000_0013;
	localparam logic [6:0]  opcImm    = 7'b0010011;
	localparam logic [6:0]  opcLoad   = 7'b0000011;
	localparam logic [6:0]  opcJalr   = 7'b1100111;
	localparam logic [6:0]  opcLui    = 7'b0110111;
	localparam logic [6:0]  opcAuipc  = 7'b0010111;

	logic        clk = 1'b0;
	logic        reset;
	logic [31:0] instruction;
	logic [31:0] dataRdData;
	logic [31:0] instrAddr;
	logic [31:0] dataAddr;
	logic [31:0] dataWrData;
	logic [3:0]  dataByteEn;
	logic        dataRead;
	logic        dataWrite;

	logic [31:0] imem [128];
	logic [31:0] dmem [64];
	integer      seed;
	int          loadIdx;
	// Expected stores in program order
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [3:0]  expBe [$];
	// Branch or jump address to the fetch address after it
	logic [31:0] branchNext [logic [31:0]];
	logic [31:0] prevAddr;
	logic        havePrev;

	riscvCore #(.regAddrWidth(5)) riscvCore_inst (
		.clk(clk), .reset(reset), .instruction(instruction), .dataRdData(dataRdData),
		.instrAddr(instrAddr), .dataAddr(dataAddr), .dataWrData(dataWrData),
		.dataByteEn(dataByteEn), .dataRead(dataRead), .dataWrite(dataWrite)
	);

	bind riscvCore riscvCore_assertions checkInst (
		.clk(clk), .reset(reset), .instruction(instruction), .instrAddr(instrAddr),
		.dataByteEn(dataByteEn), .dataRead(dataRead), .dataWrite(dataWrite)
	);

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Memory models, both answer in the same cycle
	////////////////////////////////////////////////////////////
	assign instruction = imem[instrAddr[8:2]];
	assign dataRdData  = dmem[dataAddr[7:2]];

	// Byte lane writes
	always @(posedge clk) begin
		if (dataWrite) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (dataByteEn[lane]) begin
					dmem[dataAddr[7:2]][lane*8 +: 8] <= dataWrData[lane*8 +: 8];
				end
			end
		end
	end

	// Instruction formats
	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
	endfunction

	function automatic logic [31:0] iType(input logic [6:0] op, input logic [2:0] f3,
		input int rd, input int rs1, input logic [31:0] imm);
		return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
	endfunction

	// Store, rs2 goes to imm(rs1)
	function automatic logic [31:0] sType(input logic [2:0] f3, input int rs2, input int rs1,
		input logic [31:0] imm);
		return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] bType(input logic [2:0] f3, input int rs1, input int rs2,
		input logic [31:0] imm);
		return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] uType(input logic [6:0] op, input int rd,
		input logic [19:0] imm);
		return {imm, 5'(rd), op};
	endfunction

	function automatic logic [31:0] jType(input int rd, input logic [31:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
	endfunction

	task automatic loadWord(input logic [31:0] word);
		imem[loadIdx[6:0]] = word;
		loadIdx++;
	endtask

	// Store offset is from the 0x40 base, already word aligned
	task automatic expectStore(input int offset, input logic [31:0] data, input logic [3:0] be);
		expAddr.push_back(32'h40 + offset);
		expData.push_back(data);
		expBe.push_back(be);
	endtask

	// Word indices of the redirect and its destination
	task automatic expectNext(input int fromIdx, input int toIdx);
		branchNext[32'(fromIdx) * 4] = 32'(toIdx) * 4;
	endtask

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			abortRun("value mismatch on the core outputs");
		end
	endtask

	task automatic checkStore();
		if (expAddr.size() == 0) begin
			abortRun("the core stored more often than the program does");
		end else begin
			checkValue("dataAddr", dataAddr, expAddr.pop_front());
			checkValue("dataWrData", dataWrData, expData.pop_front());
			checkValue("dataByteEn", {28'h0, dataByteEn}, {28'h0, expBe.pop_front()});
		end
	endtask

	task automatic finishRun();
		if (expAddr.size() != 0) begin
			abortRun("the program reached its end loop with stores missing");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Program image
	////////////////////////////////////////////////////////////
	task automatic buildProgram();
		// x10 store base, x1 and x2 operands
		loadWord(iType(opcImm, 3'b000, 10, 0, 32'h40));
		loadWord(iType(opcImm, 3'b000, 1, 0, 32'h123));
		loadWord(iType(opcImm, 3'b000, 2, 0, -5));
		loadWord(rType(7'h00, 3'b000, 3, 1, 2));
		loadWord(sType(3'b010, 3, 10, 0));
		loadWord(rType(7'h20, 3'b000, 3, 1, 2));
		loadWord(sType(3'b010, 3, 10, 4));
		loadWord(rType(7'h00, 3'b111, 3, 1, 2));
		loadWord(sType(3'b010, 3, 10, 8));
		loadWord(rType(7'h00, 3'b110, 3, 1, 2));
		loadWord(sType(3'b010, 3, 10, 12));
		loadWord(rType(7'h00, 3'b100, 3, 1, 2));
		loadWord(sType(3'b010, 3, 10, 16));
		// Shifts by 4
		loadWord(iType(opcImm, 3'b000, 4, 0, 32'h4));
		loadWord(rType(7'h00, 3'b001, 3, 1, 4));
		loadWord(sType(3'b010, 3, 10, 20));
		loadWord(rType(7'h00, 3'b101, 3, 2, 4));
		loadWord(sType(3'b010, 3, 10, 24));
		loadWord(rType(7'h20, 3'b101, 3, 2, 4));
		loadWord(sType(3'b010, 3, 10, 28));
		loadWord(rType(7'h00, 3'b010, 3, 2, 1));
		loadWord(sType(3'b010, 3, 10, 32));
		loadWord(rType(7'h00, 3'b011, 3, 2, 1));
		loadWord(sType(3'b010, 3, 10, 36));
		loadWord(uType(opcLui, 3, 20'habcde));
		loadWord(sType(3'b010, 3, 10, 40));
		loadWord(uType(opcAuipc, 3, 20'h00001));
		loadWord(sType(3'b010, 3, 10, 44));
		// Write to x0, then store it
		loadWord(iType(opcImm, 3'b000, 0, 1, 32'h7));
		loadWord(sType(3'b010, 0, 10, 48));
		// Loads from the two random words
		loadWord(iType(opcLoad, 3'b000, 5, 0, 32'h1));
		loadWord(sType(3'b010, 5, 10, 52));
		loadWord(iType(opcLoad, 3'b100, 5, 0, 32'h3));
		loadWord(sType(3'b010, 5, 10, 56));
		loadWord(iType(opcLoad, 3'b001, 5, 0, 32'h6));
		loadWord(sType(3'b010, 5, 10, 60));
		loadWord(iType(opcLoad, 3'b101, 5, 0, 32'h4));
		loadWord(sType(3'b010, 5, 10, 64));
		loadWord(iType(opcLoad, 3'b010, 5, 0, 32'h4));
		loadWord(sType(3'b010, 5, 10, 68));
		// Byte and half lanes, then read the word back
		loadWord(sType(3'b000, 1, 10, 72));
		loadWord(sType(3'b000, 1, 10, 73));
		loadWord(sType(3'b000, 1, 10, 74));
		loadWord(sType(3'b000, 1, 10, 75));
		loadWord(sType(3'b001, 1, 10, 76));
		loadWord(sType(3'b001, 1, 10, 78));
		loadWord(iType(opcLoad, 3'b010, 5, 10, 32'd72));
		loadWord(sType(3'b010, 5, 10, 80));
		// Branch pairs, taken skips one nop
		loadWord(bType(3'b000, 1, 1, 8));
		loadWord(nopWord);
		loadWord(bType(3'b000, 1, 2, 8));
		loadWord(bType(3'b001, 1, 2, 8));
		loadWord(nopWord);
		loadWord(bType(3'b001, 1, 1, 8));
		loadWord(bType(3'b100, 2, 1, 8));
		loadWord(nopWord);
		loadWord(bType(3'b100, 1, 2, 8));
		loadWord(bType(3'b101, 1, 2, 8));
		loadWord(nopWord);
		loadWord(bType(3'b101, 2, 1, 8));
		loadWord(bType(3'b110, 1, 2, 8));
		loadWord(nopWord);
		loadWord(bType(3'b110, 2, 1, 8));
		loadWord(bType(3'b111, 2, 1, 8));
		loadWord(nopWord);
		loadWord(bType(3'b111, 1, 2, 8));
		// Jumps and their links
		loadWord(jType(7, 8));
		loadWord(nopWord);
		loadWord(sType(3'b010, 7, 10, 84));
		loadWord(iType(opcImm, 3'b000, 8, 0, 32'h11d));
		loadWord(iType(opcJalr, 3'b000, 9, 8, 32'h4));
		loadWord(nopWord);
		loadWord(sType(3'b010, 9, 10, 88));
		loadWord(jType(0, 0));
	endtask

	// Expected results from RV32I semantics
	task automatic buildExpected();
		logic [31:0] w0;
		logic [31:0] w1;
		w0 = dmem[0];
		w1 = dmem[1];
		expectStore(0, 32'h0000_011e, 4'hf);
		expectStore(4, 32'h0000_0128, 4'hf);
		expectStore(8, 32'h0000_0123, 4'hf);
		expectStore(12, 32'hffff_fffb, 4'hf);
		expectStore(16, 32'hffff_fed8, 4'hf);
		expectStore(20, 32'h0000_1230, 4'hf);
		expectStore(24, 32'h0fff_ffff, 4'hf);
		expectStore(28, 32'hffff_ffff, 4'hf);
		expectStore(32, 32'h0000_0001, 4'hf);
		expectStore(36, 32'h0000_0000, 4'hf);
		expectStore(40, 32'habcd_e000, 4'hf);
		expectStore(44, 32'h0000_1068, 4'hf);
		expectStore(48, 32'h0000_0000, 4'hf);
		expectStore(52, {{24{w0[15]}}, w0[15:8]}, 4'hf);
		expectStore(56, {24'h0, w0[31:24]}, 4'hf);
		expectStore(60, {{16{w1[31]}}, w1[31:16]}, 4'hf);
		expectStore(64, {16'h0, w1[15:0]}, 4'hf);
		expectStore(68, w1, 4'hf);
		expectStore(72, 32'h2323_2323, 4'b0001);
		expectStore(72, 32'h2323_2323, 4'b0010);
		expectStore(72, 32'h2323_2323, 4'b0100);
		expectStore(72, 32'h2323_2323, 4'b1000);
		expectStore(76, 32'h0123_0123, 4'b0011);
		expectStore(76, 32'h0123_0123, 4'b1100);
		expectStore(80, 32'h2323_2323, 4'hf);
		expectStore(84, 32'h0000_010c, 4'hf);
		expectStore(88, 32'h0000_011c, 4'hf);
		expectNext(48, 50);
		expectNext(50, 51);
		expectNext(51, 53);
		expectNext(53, 54);
		expectNext(54, 56);
		expectNext(56, 57);
		expectNext(57, 59);
		expectNext(59, 60);
		expectNext(60, 62);
		expectNext(62, 63);
		expectNext(63, 65);
		expectNext(65, 66);
		expectNext(66, 68);
		expectNext(70, 72);
	endtask

	initial begin
		logic [31:0] firstWord;
		seed     = 32'hb6d3_6488;
		reset    = 1'b1;
		havePrev = 1'b0;
		loadIdx  = 0;
		// Unused words are nops tagged with their index
		for (int i = 0; i < 128; i++) begin
			imem[i[6:0]] = iType(opcImm, 3'b000, 0, 0, i);
		end
		for (int i = 0; i < 64; i++) begin
			dmem[i[5:0]] = {8'hd0, 2'b00, i[5:0], 10'h250, i[5:0]};
		end
		// Load test words, sign bits of the loaded lanes set
		// so sign and zero extension give different results
		dmem[0] = $random(seed) | 32'h8000_8000;
		dmem[1] = $random(seed) | 32'h8000_8000;
		buildProgram();
		buildExpected();
		// A store is fetched during reset, its strobe must stay low
		firstWord = imem[0];
		imem[0]   = sType(3'b010, 0, 0, 0);
		repeat (2) @(posedge clk);
		@(negedge clk);
		imem[0] = firstWord;
		reset <= 1'b0;
	end

	// Watchdog, three cycles per program word
	initial begin
		#(progWords * 3 * 100);
		abortRun("the program never reached its end loop");
	end

	////////////////////////////////////////////////////////////
	// Checks on the falling edge, outputs settled
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		if (riscvCore_inst.checkInst.errorCount != 0) begin
			abortRun("an assertion bound into the core failed");
		end else if (!reset) begin
			if (havePrev && branchNext.exists(prevAddr)) begin
				checkValue("instrAddr", instrAddr, branchNext[prevAddr]);
			end
			prevAddr = instrAddr;
			havePrev = 1'b1;
			if (dataWrite) begin
				checkStore();
			end
			if (instrAddr == endAddr) begin
				finishRun();
			end
		end
	end

endmodule

/* sim.f */
design/cpuPkg.sv
design/decodeIf.sv
design/controlUnit.sv
design/immExtend.sv
design/regFile.sv
design/branchUnit.sv
design/decode.sv
design/executeUnit.sv
design/riscvCore.sv
dv/riscvCore_assertions.sv
dv/riscvCoreTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = riscvCoreTb
FILELIST = sim.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, pass if $(LOG) holds the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
